/* src/lsu_pkg.sv */
////////////////////////////////////////
// types shared by the load/store unit, its aligners and the testbench
// modules pull them in by a wildcard import in their header
////////////////////////////////////////

package lsu_pkg;

  typedef logic [31:0] addr_t;    // byte address
  typedef logic [31:0] data_t;    // one bus word
  typedef logic [3:0]  be_t;      // byte enables, one per lane
  typedef logic [1:0]  offset_t;  // byte offset inside a word

  // access size, same encoding as the core's decoder (2'b11 also means byte)
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } lsu_size_e;

  // one core access as accepted on the request channel
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sign_ext;  // loads only
    addr_t     addr;      // any byte address
    data_t     wdata;     // store data, lsb aligned
  } lsu_req_t;

  typedef struct packed {
    data_t rdata;  // zero for stores
    logic  err;
  } lsu_rsp_t;

  // word-aligned transfer on the memory bus
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,                  // single or last part waiting for grant
    WAIT_RVALID,               // all grants done, waiting for final rvalid
    WAIT_GNT_MIS,              // first part of a split access waiting for grant
    WAIT_RVALID_MIS,           // second part on the bus, first rvalid still open
    WAIT_RVALID_MIS_GNTS_DONE  // both granted, first rvalid still open
  } lsu_state_e;

  // a word off its boundary or a halfword crossing lane 3 needs two transfers
  function automatic logic is_split(lsu_size_e size, offset_t off);
    return ((size == WORD) && (off != 2'b00)) || ((size == HALF) && (off == 2'b11));
  endfunction

endpackage

/* src/lsu_ctrl.sv */
////////////////////////////////////////
// load/store controller: holds one core access, splits it into one or
// two word transfers on the req/gnt/rvalid bus and raises the response
// on the final rvalid
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // core request
  input  lsu_req_t   req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  // memory bus handshake
  input  logic       mem_gnt_i,
  input  logic       mem_rvalid_i,
  input  logic       mem_err_i,
  // lanes from the store aligner
  input  be_t        be_i,
  input  data_t      wdata_i,
  output mem_req_t   mem_req_o,
  output logic       mem_req_valid_o,
  // to the aligners
  output lsu_req_t   cur_req_o,
  output logic       second_part_o,
  output logic       capture_o,
  // core response
  output logic       rsp_err_o,
  output logic       rsp_valid_o
);

  lsu_state_e state_q, state_d;
  lsu_req_t   cur_req_q;       // access being worked on
  logic       second_q, second_d;  // high once the first part is granted
  logic       err_q, err_d;    // bus error of the first part
  logic       accept;
  logic       first_rvalid;    // rvalid that belongs to the first part
  addr_t      addr_aligned;

  assign accept = req_valid_i & req_ready_o;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_d        = second_q;
    err_d           = err_q;
    req_ready_o     = 1'b0;
    mem_req_valid_o = 1'b0;
    first_rvalid    = 1'b0;
    rsp_valid_o     = 1'b0;

    unique case (state_q)
      IDLE: begin
        req_ready_o = 1'b1;  // only place a new access gets in
        if (req_valid_i) begin
          second_d = 1'b0;
          err_d    = 1'b0;
          state_d  = is_split(req_i.size, req_i.addr[1:0]) ? WAIT_GNT_MIS : WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        mem_req_valid_o = 1'b1;  // single access, or second part of a split
        if (mem_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (mem_rvalid_i) begin
          rsp_valid_o = 1'b1;  // final part back, core always takes it
          state_d     = IDLE;
        end
      end

      WAIT_GNT_MIS: begin
        mem_req_valid_o = 1'b1;  // first part at the aligned address
        if (mem_gnt_i) begin
          second_d = 1'b1;
          state_d  = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        // second part goes out while the first is still in flight
        mem_req_valid_o = 1'b1;
        if (mem_rvalid_i) begin
          first_rvalid = 1'b1;
          err_d        = mem_err_i;
          state_d      = mem_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end else if (mem_gnt_i) begin
          state_d = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        if (mem_rvalid_i) begin
          first_rvalid = 1'b1;  // second rvalid comes on a later cycle
          err_d        = mem_err_i;
          state_d      = WAIT_RVALID;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      second_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      second_q <= second_d;
      err_q    <= err_d;
    end
  end

  // request payload, only meaningful outside IDLE
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_req_q <= req_i;
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign addr_aligned = {cur_req_q.addr[31:2], 2'b00};

  assign mem_req_o = '{
    addr:  second_q ? addr_aligned + 32'd4 : addr_aligned,  // next word for part two
    we:    cur_req_q.we,
    be:    be_i,
    wdata: wdata_i
  };

  assign cur_req_o     = cur_req_q;
  assign second_part_o = second_q;
  assign capture_o     = first_rvalid & ~cur_req_q.we;  // stores have nothing to keep
  assign rsp_err_o     = err_q | mem_err_i;             // either part failing fails all

endmodule

/* src/lsu_store_align.sv */
////////////////////////////////////////
// store side lanes: byte enables per part and wdata rotation
// purely combinational, driven from the held request
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*; (
  input  lsu_req_t cur_req_i,
  input  logic     second_part_i,  // high for the transfer at aligned + 4
  output be_t      be_o,
  output data_t    wdata_o
);

  offset_t    off;
  offset_t    lane;        // destination lane in the rotation loop
  be_t        size_mask;   // lanes touched when the access is aligned
  logic [7:0] be_wide;     // enables over two words, low half is part one

  assign off = cur_req_i.addr[1:0];

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb begin
    unique case (cur_req_i.size)
      WORD:    size_mask = 4'b1111;
      HALF:    size_mask = 4'b0011;
      default: size_mask = 4'b0001;  // byte, both encodings
    endcase
  end

  // shift by the offset, whatever falls past lane 3 belongs to part two
  assign be_wide = {4'b0000, size_mask} << off;
  assign be_o    = second_part_i ? be_wide[7:4] : be_wide[3:0];

  ////////////////////////////////////////
  // wdata rotation
  ////////////////////////////////////////

  // byte i of the data goes to lane off+i, wrapping into the low lanes,
  // so both parts can use the same word
  always_comb begin
    wdata_o = '0;
    for (int unsigned i = 0; i < 4; i++) begin
      lane = off + offset_t'(i);  // 2-bit add wraps mod 4
      wdata_o[lane*8 +: 8] = cur_req_i.wdata[i*8 +: 8];
    end
  end

endmodule

/* src/lsu_load_align.sv */
////////////////////////////////////////
// load side: keeps the upper bytes of the first part's word, then
// realigns and extends the result on the final rvalid
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  lsu_req_t cur_req_i,
  input  logic     capture_i,    // first part's rvalid on a load
  input  data_t    mem_rdata_i,
  output data_t    rdata_o
);

  logic [23:0] held_q;   // bytes 1..3 of the first word
  offset_t     off;
  logic        split;
  logic [63:0] window;   // byte stream starting at the aligned address
  data_t       shifted;  // window moved down to the access's first byte

  assign off   = cur_req_i.addr[1:0];
  assign split = is_split(cur_req_i.size, off);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= '0;
    end else if (capture_i) begin
      held_q <= mem_rdata_i[31:8];  // byte 0 is never needed by a split
    end
  end

  ////////////////////////////////////////
  // realignment
  ////////////////////////////////////////

  // split: held word below, current word above
  // single: the current word alone carries every byte
  always_comb begin
    if (split) begin
      window = {mem_rdata_i, held_q, 8'h00};
    end else begin
      window = {32'h0000_0000, mem_rdata_i};
    end
  end

  always_comb begin
    unique case (off)
      2'b00:   shifted = window[31:0];
      2'b01:   shifted = window[39:8];
      2'b10:   shifted = window[47:16];
      default: shifted = window[55:24];
    endcase
  end

  ////////////////////////////////////////
  // extension
  ////////////////////////////////////////

  always_comb begin
    if (cur_req_i.we) begin
      rdata_o = '0;  // stores return no data
    end else begin
      unique case (cur_req_i.size)
        WORD: rdata_o = shifted;
        HALF: rdata_o = {{16{cur_req_i.sign_ext & shifted[15]}}, shifted[15:0]};
        default: begin
          rdata_o = {{24{cur_req_i.sign_ext & shifted[7]}}, shifted[7:0]};  // byte
        end
      endcase
    end
  end

endmodule

/* src/lsu_top.sv */
////////////////////////////////////////
// load/store unit top: core valid/ready request, valid-only response,
// word-aligned req/gnt/rvalid memory bus
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // core side
  input  lsu_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output lsu_rsp_t rsp_o,
  output logic     rsp_valid_o,
  // memory side
  output mem_req_t mem_req_o,
  output logic     mem_req_valid_o,
  input  logic     mem_gnt_i,
  input  logic     mem_rvalid_i,
  input  data_t    mem_rdata_i,
  input  logic     mem_err_i
);

  lsu_req_t cur_req;      // held access, feeds both aligners
  logic     second_part;
  logic     capture;
  be_t      be;
  data_t    wdata;
  data_t    rdata;
  logic     rsp_err;

  lsu_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .mem_gnt_i       (mem_gnt_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_err_i       (mem_err_i),
    .be_i            (be),
    .wdata_i         (wdata),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .cur_req_o       (cur_req),
    .second_part_o   (second_part),
    .capture_o       (capture),
    .rsp_err_o       (rsp_err),
    .rsp_valid_o     (rsp_valid_o)
  );

  lsu_store_align u_store_align (
    .cur_req_i     (cur_req),
    .second_part_i (second_part),
    .be_o          (be),
    .wdata_o       (wdata)
  );

  lsu_load_align u_load_align (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cur_req_i   (cur_req),
    .capture_i   (capture),
    .mem_rdata_i (mem_rdata_i),
    .rdata_o     (rdata)
  );

  assign rsp_o = '{rdata: rdata, err: rsp_err};  // response fields from two blocks

endmodule

/* sim/lsu_chk.sv */
////////////////////////////////////////
// bus and handshake assertions, bound into every lsu_top instance
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_chk import lsu_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     req_ready_o,
  input logic     rsp_valid_o,
  input mem_req_t mem_req_o,
  input logic     mem_req_valid_o,
  input logic     mem_gnt_i
);

  int unsigned fail_cnt = 0;  // assertion failures so far

  // every bus transfer sits on a word boundary
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o |-> mem_req_o.addr[1:0] == 2'b00)
  else begin
    $error("bus address not word aligned: %h", mem_req_o.addr);
    fail_cnt++;
  end

  // strobe stays up with address, enables and data unchanged until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_gnt_i |=> mem_req_valid_o && $stable(mem_req_o))
  else begin
    $error("bus request dropped or changed before its grant");
    fail_cnt++;
  end

  // ready only comes back on the edge after a response, one access per response
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ready_o && !$past(req_ready_o) |-> $past(rsp_valid_o))
  else begin
    $error("request channel reopened without a response");
    fail_cnt++;
  end

endmodule

bind lsu_top lsu_chk u_chk (.*);

/* sim/lsu_tb.sv */
////////////////////////////////////////
// testbench for the load/store unit: random latency memory model,
// shadow byte array as reference, response checker and report
////////////////////////////////////////

`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam int NUM_TXN = 116;  // 21 aligned, 12 split, 60 random, 3 error, 20 back-to-back

  typedef struct packed {
    lsu_rsp_t    rsp;
    addr_t       addr0;  // aligned address of the first transfer
    logic [1:0]  nxfer;
    logic [31:0] base;   // transfer log length at acceptance
  } exp_t;

  typedef struct packed {
    data_t data;
    logic  err;
  } beat_t;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  lsu_req_t req_i;
  logic     req_valid_i;
  logic     req_ready_o;
  lsu_rsp_t rsp_o;
  logic     rsp_valid_o;
  mem_req_t mem_req_o;
  logic     mem_req_valid_o;
  logic     mem_gnt_i;
  logic     mem_rvalid_i;
  data_t    mem_rdata_i;
  logic     mem_err_i;

  data_t       mem [64];      // bus side memory
  logic [7:0]  shadow [256];  // reference copy, byte wise
  beat_t       pend_q [$];    // granted reads waiting for rvalid, in order
  addr_t       xfer_log [$];  // address of every granted transfer
  exp_t        exp_q [$];
  logic [31:0] bus_seed = 32'd81653;
  logic [31:0] stim_seed = 32'd81653;
  logic [1:0]  gnt_wait = 2'd0;
  logic [1:0]  rv_wait = 2'd0;
  int          err_word = -1;  // word that answers with err, -1 for none
  int unsigned overlap_cnt = 0, checks = 0, errors = 0;
  int unsigned accepted = 0, responses = 0, test_txn = 0, test_errs = 0;
  string       test_name = "reset";

  lsu_top dut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [1:0] bus_rand();
    bus_seed = lcg(bus_seed);
    return bus_seed[29:28];  // 0 to 3 cycles
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_seed = lcg(stim_seed);
    return stim_seed;
  endfunction

  function automatic logic [7:0] fill_byte(int b);
    return 8'(b * 37) ^ 8'hA5;  // varies with every address bit
  endfunction

  function automatic int unsigned access_bytes(lsu_size_e size);
    return (size == WORD) ? 4 : (size == HALF) ? 2 : 1;
  endfunction

  // access runs past lane 3 into the next word
  function automatic logic crosses_word(lsu_req_t r);
    return (r.addr[1:0] + access_bytes(r.size)) > 4;
  endfunction

  // expected response from the shadow bytes
  function automatic lsu_rsp_t expect_rsp(lsu_req_t r);
    int unsigned n;
    int          w0;
    data_t       v;
    lsu_rsp_t    rsp;
    n  = access_bytes(r.size);
    w0 = r.addr[7:2];
    v  = '0;
    for (int i = 0; i < n; i++) begin
      v[i*8 +: 8] = shadow[(r.addr[7:0] + i) % 256];  // byte i from addr + i
    end
    if (r.sign_ext && n < 4 && v[n*8-1]) begin
      v = v | ~((32'd1 << (n * 8)) - 32'd1);
    end
    rsp.rdata = r.we ? '0 : v;
    rsp.err   = (w0 == err_word) || (crosses_word(r) && ((w0 + 1) % 64 == err_word));
    return rsp;
  endfunction

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errs++;
      $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    int w;
    if (rst_ni) begin
      if (mem_rvalid_i) begin
        pend_q.delete(0);
        rv_wait = bus_rand();
      end
      if (mem_req_valid_o && mem_gnt_i) begin
        w = mem_req_o.addr[7:2];
        if (pend_q.size() != 0) begin
          overlap_cnt++;  // granted while an earlier read is open
        end
        xfer_log.push_back(mem_req_o.addr);
        for (int j = 0; j < 4; j++) begin
          if (mem_req_o.we && mem_req_o.be[j]) begin
            mem[w][j*8 +: 8] = mem_req_o.wdata[j*8 +: 8];
          end
        end
        pend_q.push_back('{data: mem[w], err: (w == err_word)});
        gnt_wait = bus_rand();
      end
    end
    #1;
    mem_gnt_i = (gnt_wait == 2'd0);
    if (gnt_wait != 2'd0) gnt_wait--;
    mem_rvalid_i = (pend_q.size() != 0) && (rv_wait == 2'd0);
    mem_rdata_i  = mem_rvalid_i ? pend_q[0].data : '0;
    mem_err_i    = mem_rvalid_i ? pend_q[0].err : 1'b0;
    if (pend_q.size() != 0 && rv_wait != 2'd0) rv_wait--;
  end

  ////////////////////////////////////////
  // stimulus and comparison
  ////////////////////////////////////////

  // returns 1 ns after the accept edge with valid still high
  task automatic send_request(logic we, lsu_size_e size, logic sext, addr_t addr, data_t wdata);
    lsu_req_t r;
    exp_t     e;
    r = '{we: we, size: size, sign_ext: sext, addr: addr, wdata: wdata};
    req_i       = r;
    req_valid_i = 1'b1;
    do @(posedge clk_i); while (!req_ready_o);
    e.rsp   = expect_rsp(r);
    e.addr0 = {addr[31:2], 2'b00};
    e.nxfer = crosses_word(r) ? 2'd2 : 2'd1;
    e.base  = xfer_log.size();
    exp_q.push_back(e);
    for (int i = 0; i < access_bytes(size); i++) begin
      if (we) shadow[(addr[7:0] + i) % 256] = wdata[i*8 +: 8];
    end
    accepted++;
    test_txn++;
    #1;
  endtask

  task automatic wait_response();
    req_valid_i = 1'b0;
    do @(posedge clk_i); while (!rsp_valid_o);
    #1;
  endtask

  task automatic store_then_load(lsu_size_e size, addr_t addr);
    send_request(1'b1, size, 1'b0, addr, stim_rand());
    wait_response();
    send_request(1'b0, size, 1'b0, addr, '0);
    wait_response();
    send_request(1'b0, size, 1'b1, addr, '0);
    wait_response();
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_txn  = 0;
    test_errs = 0;
  endtask

  task automatic finish_test();
    $display("%-14s %0d transactions, %0d errors", test_name, test_txn, test_errs);
  endtask

  always @(posedge clk_i) begin
    exp_t e;
    if (rst_ni && rsp_valid_o) begin
      responses++;
      if (exp_q.size() == 0) begin
        errors++;
        test_errs++;
        $display("%s: a response arrived with no request outstanding", test_name);
      end else begin
        e = exp_q.pop_front();
        check_value("rdata", e.rsp.rdata, rsp_o.rdata);
        check_value("err", e.rsp.err, rsp_o.err);
        check_value("transfers", e.nxfer, xfer_log.size() - e.base);
        check_value("addr 1", e.addr0, xfer_log[e.base]);
        if (e.nxfer == 2'd2) check_value("addr 2", e.addr0 + 32'd4, xfer_log[e.base + 1]);
      end
    end
  end

  initial begin
    logic [31:0] rnd;
    req_i        = '0;
    req_valid_i  = 1'b0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_err_i    = 1'b0;
    rst_ni       = 1'b0;
    for (int b = 0; b < 256; b++) begin
      shadow[b] = fill_byte(b);
      mem[b / 4][(b % 4) * 8 +: 8] = fill_byte(b);
    end
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    start_test("aligned");
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off += (4 >> s)) begin  // every legal offset per size
        store_then_load(lsu_size_e'(s), 32'h20 + (s * 4 + off) * 4 + off);
      end
    end
    finish_test();

    start_test("misaligned");
    for (int k = 1; k < 5; k++) begin
      store_then_load(k < 4 ? WORD : HALF, 32'h80 + k * 8 + (k < 4 ? k : 3));  // k 4 is half at 3
    end
    finish_test();

    start_test("random");
    for (int k = 0; k < 60; k++) begin
      rnd = stim_rand();
      send_request(rnd[31], lsu_size_e'(rnd[30:29] % 2'd3), rnd[28], {24'h0, rnd[7:0]},
                   stim_rand());
      wait_response();
    end
    finish_test();

    start_test("bus_error");
    err_word = 10;
    send_request(1'b0, WORD, 1'b0, 32'd41, '0);  // first part on word 10
    wait_response();
    send_request(1'b0, WORD, 1'b0, 32'd38, '0);  // second part on word 10
    wait_response();
    send_request(1'b0, BYTE, 1'b1, 32'd42, '0);  // single transfer
    wait_response();
    err_word = -1;
    finish_test();

    start_test("back_pressure");
    for (int k = 0; k < 20; k++) begin
      rnd = stim_rand();
      send_request(rnd[31], lsu_size_e'(rnd[30:29] % 2'd3), rnd[28], {24'h0, rnd[7:0]},
                   stim_rand());  // valid stays high into the busy cycles
    end
    wait_response();
    check_value("accepts vs responses", accepted, responses);
    finish_test();

    if (overlap_cnt == 0) begin
      errors++;
      $display("no grant ever arrived while an earlier read was still open");
    end
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             dut.u_chk.fail_cnt);
    if (errors == 0 && dut.u_chk.fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog, 200 cycles for each transaction
  initial begin
    repeat (NUM_TXN * 200) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", NUM_TXN * 200);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* lsu_top.f */
src/lsu_pkg.sv
src/lsu_ctrl.sv
src/lsu_store_align.sv
src/lsu_load_align.sv
src/lsu_top.sv
sim/lsu_chk.sv
sim/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - src/lsu_pkg.sv
  - src/lsu_ctrl.sv
  - src/lsu_store_align.sv
  - src/lsu_load_align.sv
  - src/lsu_top.sv
  - target: simulation
    files:
      - sim/lsu_chk.sv
      - sim/lsu_tb.sv
